/* filelist.f */
verilog/regop_pkg.sv
verilog/axil_cmd_in.sv
verilog/reg_file.sv
verilog/regop_exec.sv
verilog/axil_reg_out.sv
verilog/regop_top.sv
test/regop_tb.sv

/* test/regop_tb.sv */
`timescale 1ns/1ps

module regop_tb;
	import regop_pkg::*;

	localparam logic [31:0] SEED = 32'h7f443de5;
	localparam int NUM_LDI   = 16;
	localparam int NUM_RAND  = 200;
	localparam int NUM_BAD   = 4;
	// Four sweeps, write plus read per instruction, three error beats per round, one clear
	localparam int NUM_TRANS = 4 * NUM_REGS + 2 * (NUM_LDI + NUM_RAND) + 3 * NUM_BAD + 1;
	localparam int CYCLE_LIMIT = NUM_TRANS * 20 + 10;

	logic              clk;
	logic              rst_n;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [WORD_W-1:0] wdata;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [WORD_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;

	logic [31:0] lfsr;
	logic [31:0] model [NUM_REGS];
	logic [31:0] exp_data [$];
	logic [1:0]  exp_resp [$];
	int          cycles;

	regop_top uut (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #20 clk = ~clk;

	task automatic report_mismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected destination value from the opcode rules
	function automatic logic [31:0] expected_result(input logic [31:0] instr,
			input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = instr[SH_MSB:SH_LSB];
		case (instr[OP_MSB:OP_LSB])
			OP_ADD: return a + b;
			OP_SUB: return a + ~b + 32'd1;
			OP_AND: return a & b;
			OP_OR:  return a | b;
			OP_XOR: return a ^ b;
			// With differing signs the negative one is smaller
			OP_SLT: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			OP_SLL: return b << sh;
			OP_SRL: return b >> sh;
			OP_LDI: return {16'b0, instr[15:0]};
			default: return '0;
		endcase
	endfunction

	function automatic logic [4:0] dest_of(input logic [31:0] instr);
		return (instr[OP_MSB:OP_LSB] == OP_LDI) ? instr[RT_MSB:RT_LSB] : instr[RD_MSB:RD_LSB];
	endfunction

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [1:0] want_resp, input int want_lat);
		int lat;
		int stall;
		logic [1:0] seen;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		assert (wready)
			else report_mismatch($sformatf("addr %h awready high with wready low", addr));
		// Handshake edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clk);
		lat = 1;
		while (!bvalid)
		begin
			@(negedge clk);
			lat++;
		end
		seen = bresp;
		assert (lat == want_lat)
			else report_mismatch($sformatf("addr %h bvalid after %0d cycles, expected %0d",
				addr, lat, want_lat));
		assert (seen == want_resp)
			else report_mismatch($sformatf("addr %h bresp %0d, expected %0d",
				addr, seen, want_resp));
		stall = take_bits(3);
		repeat (stall)
		begin
			@(negedge clk);
			assert (bvalid && bresp == seen)
				else report_mismatch("B beat changed while bready was low");
		end
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, input logic [31:0] want_data,
			input logic [1:0] want_resp);
		int stall;
		logic [31:0] held_d;
		logic [1:0] held_r;
		exp_data.push_back(want_data);
		exp_resp.push_back(want_resp);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		held_d = rdata;
		held_r = rresp;
		stall = take_bits(3);
		repeat (stall)
		begin
			@(negedge clk);
			assert (rvalid && !arready && rdata == held_d && rresp == held_r)
				else report_mismatch($sformatf("R beat for addr %h changed while rready was low",
					addr));
		end
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic sweep();
		for (int i = 0; i < NUM_REGS; i++)
			axi_read(8'(i * 4), model[i], RESP_OKAY);
	endtask

	task automatic run_instr(input logic [31:0] instr);
		logic [4:0] idx;
		logic [31:0] val;
		idx = dest_of(instr);
		// Operands come from the model before the write-back
		val = expected_result(instr, model[instr[RS_MSB:RS_LSB]], model[instr[RT_MSB:RT_LSB]]);
		axi_write(INSTR_ADDR, instr, RESP_OKAY, 3);
		model[idx] = val;
		axi_read({1'b0, idx, 2'b00}, val, RESP_OKAY);
	endtask

	////////////////////////////////////////
	// R beat compare and timeout
	////////////////////////////////////////
	always @(negedge clk)
	begin : compare_r
		logic [31:0] want_d;
		logic [1:0] want_r;
		if (rst_n && rvalid && rready)
		begin
			assert (exp_data.size() != 0)
				else abort_run("A read data beat arrived with no read outstanding");
			want_d = exp_data.pop_front();
			want_r = exp_resp.pop_front();
			assert (rdata == want_d && rresp == want_r)
				else report_mismatch($sformatf("rdata %h rresp %0d, expected %h rresp %0d",
					rdata, rresp, want_d, want_r));
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			abort_run($sformatf("Timeout, the run did not finish in %0d cycles", CYCLE_LIMIT));
	end

	initial
	begin
		logic [31:0] instr;
		logic [31:0] r;
		logic [7:0] addr;
		clk     = 1'b0;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		cycles  = 0;
		lfsr    = SEED;
		for (int i = 0; i < NUM_REGS; i++)
			model[i] = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!bvalid && !rvalid && !awready && !wready && arready)
			else report_mismatch("handshake outputs wrong after reset");
		sweep();
		repeat (NUM_LDI)
		begin
			instr = take_bits(32);
			instr[OP_MSB:OP_LSB] = OP_LDI;
			run_instr(instr);
		end
		// Top opcode bit cleared gives ADD through SRL
		repeat (NUM_RAND)
		begin
			instr = take_bits(32);
			instr[OP_MSB] = 1'b0;
			run_instr(instr);
		end
		sweep();
		repeat (NUM_BAD)
		begin
			instr = take_bits(32);
			r = take_bits(3);
			instr[OP_MSB:OP_LSB] = 4'(9 + r % 7);
			axi_write(INSTR_ADDR, instr, RESP_SLVERR, 1);
			r = take_bits(8);
			addr = r[7:0];
			if (addr == INSTR_ADDR || addr == CLEAR_ADDR)
				addr = addr + 8'd8;
			instr = take_bits(32);
			instr[OP_MSB] = 1'b0;
			axi_write(addr, instr, RESP_SLVERR, 1);
			r = take_bits(7);
			axi_read(8'h80 | r[7:0], '0, RESP_SLVERR);
		end
		// Nothing above may have touched the bank
		sweep();
		axi_write(CLEAR_ADDR, take_bits(32), RESP_OKAY, 3);
		for (int i = 0; i < NUM_REGS; i++)
			model[i] = '0;
		sweep();
		assert (exp_data.size() == 0)
		begin
			$display("No errors");
			$finish;
		end
		else
			abort_run("Some expected read beats never arrived");
	end

endmodule

/* verilog/regop_top.sv */
`timescale 1ns/1ps

module regop_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [regop_pkg::ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [regop_pkg::WORD_W-1:0] wdata,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [regop_pkg::ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [regop_pkg::WORD_W-1:0] rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready
);
	import regop_pkg::*;

	logic              cmd_valid;
	logic              cmd_clear;
	logic [WORD_W-1:0] cmd_instr;
	logic              cmd_done;
	logic [IDX_W-1:0]  rd_addr_a;
	logic [IDX_W-1:0]  rd_addr_b;
	logic [WORD_W-1:0] rd_data_a;
	logic [WORD_W-1:0] rd_data_b;
	logic              wr_en;
	logic [IDX_W-1:0]  wr_addr;
	logic [WORD_W-1:0] wr_data;
	logic              clear;
	logic [IDX_W-1:0]  host_addr;
	logic [WORD_W-1:0] host_data;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////
	axil_cmd_in u_cmd_in (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.cmd_valid(cmd_valid), .cmd_clear(cmd_clear),
		.cmd_instr(cmd_instr), .cmd_done(cmd_done)
	);

	regop_exec u_exec (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_clear(cmd_clear), .cmd_instr(cmd_instr),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.clear(clear), .cmd_done(cmd_done)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .host_addr(host_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .clear(clear),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .host_data(host_data)
	);

	// Read side
	axil_reg_out u_reg_out (
		.clk(clk), .rst_n(rst_n),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.host_addr(host_addr), .host_data(host_data)
	);

endmodule

/* verilog/axil_reg_out.sv */
`timescale 1ns/1ps

module axil_reg_out (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [regop_pkg::ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [regop_pkg::WORD_W-1:0] rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output logic [regop_pkg::IDX_W-1:0]  host_addr,
	input  logic [regop_pkg::WORD_W-1:0] host_data
);
	import regop_pkg::*;

	logic ar_hs;
	logic in_range;

	assign arready   = !rvalid;
	assign ar_hs     = arvalid && arready;
	// Word index from the byte address
	assign host_addr = araddr[IDX_W+1:2];
	assign in_range  = (araddr <= REG_WINDOW_LAST);

	// R beat held until the host takes it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
		end
		else if (ar_hs)
		begin
			rvalid <= 1'b1;
			rresp  <= in_range ? RESP_OKAY : RESP_SLVERR;
		end
		else if (rvalid && rready)
		begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ar_hs)
			rdata <= in_range ? host_data : '0;
	end

endmodule

/* verilog/regop_exec.sv */
`timescale 1ns/1ps

module regop_exec (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         cmd_valid,
	input  logic                         cmd_clear,
	input  logic [regop_pkg::WORD_W-1:0] cmd_instr,
	output logic [regop_pkg::IDX_W-1:0]  rd_addr_a,
	output logic [regop_pkg::IDX_W-1:0]  rd_addr_b,
	input  logic [regop_pkg::WORD_W-1:0] rd_data_a,
	input  logic [regop_pkg::WORD_W-1:0] rd_data_b,
	output logic                         wr_en,
	output logic [regop_pkg::IDX_W-1:0]  wr_addr,
	output logic [regop_pkg::WORD_W-1:0] wr_data,
	output logic                         clear,
	output logic                         cmd_done
);
	import regop_pkg::*;

	exec_state_t state;
	exec_state_t phase;

	logic                   clr_q;
	alu_op_t                op_q;
	logic [IDX_W-1:0]       rt_q;
	logic [IDX_W-1:0]       rd_q;
	logic [SH_MSB:SH_LSB]   shamt_q;
	logic [IMM_MSB:IMM_LSB] imm_q;
	logic [WORD_W-1:0]      opa_q;
	logic [WORD_W-1:0]      opb_q;
	logic [WORD_W-1:0]      alu_res;

	// A command in flight is the operand cycle
	assign phase = cmd_valid ? EX_OPERANDS : state;

	// Source registers straight from the held instruction
	assign rd_addr_a = cmd_instr[RS_MSB:RS_LSB];
	assign rd_addr_b = cmd_instr[RT_MSB:RT_LSB];

	////////////////////////////////////////
	// State and operand latch
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= EX_IDLE;
			clr_q <= 1'b0;
		end
		else
		begin
			case (phase)
				EX_OPERANDS:
				begin
					state <= EX_WRITE;
					clr_q <= cmd_clear;
				end
				EX_WRITE: state <= EX_IDLE;
				default:  state <= EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == EX_OPERANDS)
		begin
			op_q    <= alu_op_t'(cmd_instr[OP_MSB:OP_LSB]);
			rt_q    <= cmd_instr[RT_MSB:RT_LSB];
			rd_q    <= cmd_instr[RD_MSB:RD_LSB];
			shamt_q <= cmd_instr[SH_MSB:SH_LSB];
			imm_q   <= cmd_instr[IMM_MSB:IMM_LSB];
			opa_q   <= rd_data_a;
			opb_q   <= rd_data_b;
		end
	end

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb
	begin
		case (op_q)
			OP_ADD: alu_res = opa_q + opb_q;
			OP_SUB: alu_res = opa_q - opb_q;
			OP_AND: alu_res = opa_q & opb_q;
			OP_OR:  alu_res = opa_q | opb_q;
			OP_XOR: alu_res = opa_q ^ opb_q;
			OP_SLT: alu_res = ($signed(opa_q) < $signed(opb_q)) ? WORD_W'(1) : '0;
			// Shifts act on rt
			OP_SLL: alu_res = opb_q << shamt_q;
			OP_SRL: alu_res = opb_q >> shamt_q;
			OP_LDI: alu_res = {{(WORD_W - (IMM_MSB - IMM_LSB + 1)){1'b0}}, imm_q};
			default: alu_res = '0;
		endcase
	end

	// Load immediate targets rt instead of rd
	assign wr_addr  = (op_q == OP_LDI) ? rt_q : rd_q;
	assign wr_data  = alu_res;
	assign wr_en    = (state == EX_WRITE) && !clr_q;
	assign clear    = (state == EX_WRITE) && clr_q;
	assign cmd_done = (state == EX_WRITE);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [regop_pkg::IDX_W-1:0]  rd_addr_a,
	input  logic [regop_pkg::IDX_W-1:0]  rd_addr_b,
	input  logic [regop_pkg::IDX_W-1:0]  host_addr,
	input  logic                         wr_en,
	input  logic [regop_pkg::IDX_W-1:0]  wr_addr,
	input  logic [regop_pkg::WORD_W-1:0] wr_data,
	input  logic                         clear,
	output logic [regop_pkg::WORD_W-1:0] rd_data_a,
	output logic [regop_pkg::WORD_W-1:0] rd_data_b,
	output logic [regop_pkg::WORD_W-1:0] host_data
);
	import regop_pkg::*;

	logic [WORD_W-1:0] bank [NUM_REGS];

	// Register 0 is an ordinary writable register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				bank[i] <= '0;
		end
		else if (clear)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				bank[i] <= '0;
		end
		else if (wr_en)
		begin
			bank[wr_addr] <= wr_data;
		end
	end

	// Combinational read ports
	assign rd_data_a = bank[rd_addr_a];
	assign rd_data_b = bank[rd_addr_b];
	// Host port sees the value before a same-cycle write
	assign host_data = bank[host_addr];

endmodule

/* verilog/axil_cmd_in.sv */
`timescale 1ns/1ps

module axil_cmd_in (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [regop_pkg::ADDR_W-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [regop_pkg::WORD_W-1:0] wdata,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	output logic                          cmd_valid,
	output logic                          cmd_clear,
	output logic [regop_pkg::WORD_W-1:0] cmd_instr,
	input  logic                          cmd_done
);
	import regop_pkg::*;

	logic       pending;
	logic       accept;
	logic       op_legal;
	logic [3:0] opcode;

	// Address and data are taken together in one beat
	assign accept  = awvalid && wvalid && !pending && !bvalid;
	assign awready = accept;
	assign wready  = accept;

	assign opcode   = wdata[OP_MSB:OP_LSB];
	assign op_legal = (opcode <= OP_LDI);

	////////////////////////////////////////
	// Decode and B channel
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_valid <= 1'b0;
			cmd_clear <= 1'b0;
			pending   <= 1'b0;
			bvalid    <= 1'b0;
			bresp     <= RESP_OKAY;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (accept)
			begin
				if (awaddr == INSTR_ADDR && op_legal)
				begin
					cmd_valid <= 1'b1;
					cmd_clear <= 1'b0;
					pending   <= 1'b1;
				end
				else if (awaddr == CLEAR_ADDR)
				begin
					cmd_valid <= 1'b1;
					cmd_clear <= 1'b1;
					pending   <= 1'b1;
				end
				else
				begin
					// Bad opcode or unmapped address, answer at once
					bvalid <= 1'b1;
					bresp  <= RESP_SLVERR;
				end
			end
			// Executor finished, retire the write
			if (cmd_done)
			begin
				pending <= 1'b0;
				bvalid  <= 1'b1;
				bresp   <= RESP_OKAY;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			cmd_instr <= wdata;
	end

endmodule

/* verilog/regop_pkg.sv */
package regop_pkg;

	// Word and register index sizes fixed by the instruction format
	localparam int WORD_W   = 32;
	localparam int IDX_W    = 5;
	localparam int NUM_REGS = 2 ** IDX_W;
	localparam int ADDR_W   = 8;

	// Opcode in instruction bits 31..28, codes 9 to 15 are illegal
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLT = 4'd5,
		OP_SLL = 4'd6,
		OP_SRL = 4'd7,
		OP_LDI = 4'd8
	} alu_op_t;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_OPERANDS,
		EX_WRITE
	} exec_state_t;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////
	localparam logic [ADDR_W-1:0] INSTR_ADDR      = 8'h00;
	localparam logic [ADDR_W-1:0] CLEAR_ADDR      = 8'h04;
	localparam logic [ADDR_W-1:0] REG_WINDOW_LAST = 8'h7C;

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////
	localparam int OP_MSB  = 31;
	localparam int OP_LSB  = 28;
	localparam int RS_MSB  = 25;
	localparam int RS_LSB  = 21;
	localparam int RT_MSB  = 20;
	localparam int RT_LSB  = 16;
	localparam int RD_MSB  = 15;
	localparam int RD_LSB  = 11;
	localparam int SH_MSB  = 10;
	localparam int SH_LSB  = 6;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
